// File: Bender.yml
package:
  name: neuro_vector_unit

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/nvu_pkg.sv
      - rtl/vector_reg_bank.sv
      - rtl/neuron_param_regs.sv
      - rtl/current_accumulator.sv
      - rtl/neuron_fire_unit.sv
      - rtl/neuro_vector_unit.sv

  - target: test
    include_dirs:
      - rtl
    files:
      - tests/tb_neuro_vector_unit.sv

// File: filelist.f
+incdir+rtl
rtl/nvu_pkg.sv
rtl/vector_reg_bank.sv
rtl/neuron_param_regs.sv
rtl/current_accumulator.sv
rtl/neuron_fire_unit.sv
rtl/neuro_vector_unit.sv
tests/tb_neuro_vector_unit.sv

// File: rtl/current_accumulator.sv
`timescale 1ns/1ps
`include "nvu_cfg.svh"

module current_accumulator
    import nvu_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  neuron_cmd_t  cmd,
    input  data_bus_t    data,
    input  bank_vec_t    weights,
    input  bank_vec_t    spike_words,
    input  spike_vec_t   fire_clear,
    output current_vec_t currents
);

    spike_vec_t   spike_window;   // Four spike words starting at cmd.idx
    current_vec_t acc_sum;        // Gated sums for ACCUMULATE
    current_vec_t keep_mask;      // Zero nibbles for fired neurons

    // Window of 128 spike bits that starts at word idx and wraps around the bank
    always_comb begin
        bank_idx_t widx;
        for (int k = 0; k < 4; k++) begin
            widx = cmd.idx + bank_idx_t'(k);
            spike_window[k*`NVU_WORD_W +: `NVU_WORD_W] =
                spike_words[widx*`NVU_WORD_W +: `NVU_WORD_W];
        end
    end

    always_comb begin
        cell_t gated_w;
        for (int i = 0; i < `NVU_NEURONS; i++) begin
            gated_w = spike_window[i] ? weights[i*`NVU_CELL_W +: `NVU_CELL_W] : '0;
            acc_sum[i*`NVU_CELL_W +: `NVU_CELL_W] =
                currents[i*`NVU_CELL_W +: `NVU_CELL_W] + gated_w;  // Wraps modulo 16
            keep_mask[i*`NVU_CELL_W +: `NVU_CELL_W] = {`NVU_CELL_W{~fire_clear[i]}};
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            currents <= '0;
        end else begin
            case (cmd.op)
                LOAD_CURRENT: begin
                    currents <= data;
                end
                ACCUMULATE: begin
                    currents <= acc_sum;
                end
                UPDATE: begin
                    currents <= currents & keep_mask;  // Fired neurons restart from zero
                end
                default: begin
                end
            endcase
        end
    end

endmodule

// File: rtl/neuro_vector_unit.sv
`timescale 1ns/1ps

module neuro_vector_unit
    import nvu_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  reg_cmd_t     w_cmd,
    input  reg_cmd_t     s_cmd,
    input  neuron_cmd_t  n_cmd,
    input  data_bus_t    data,
    output current_vec_t currents,
    output spike_vec_t   spikes,
    output logic         refractory
);

    bank_vec_t  weight_words;
    bank_vec_t  spike_words;
    cell_t      threshold;
    refrac_t    refrac_reload;
    spike_vec_t fire_clear;

    // Weight bank with one 4-bit weight per neuron
    vector_reg_bank weight_bank0 (
        .clk   (clk),
        .reset (reset),
        .cmd   (w_cmd),
        .data  (data),
        .words (weight_words)
    );

    // Spike bank holding one bit per synapse
    vector_reg_bank spike_bank0 (
        .clk   (clk),
        .reset (reset),
        .cmd   (s_cmd),
        .data  (data),
        .words (spike_words)
    );

    neuron_param_regs param_regs0 (
        .clk           (clk),
        .reset         (reset),
        .cmd           (n_cmd),
        .data          (data),
        .threshold     (threshold),
        .refrac_reload (refrac_reload)
    );

    current_accumulator accumulator0 (
        .clk         (clk),
        .reset       (reset),
        .cmd         (n_cmd),
        .data        (data),
        .weights     (weight_words),
        .spike_words (spike_words),
        .fire_clear  (fire_clear),
        .currents    (currents)
    );

    neuron_fire_unit fire_unit0 (
        .clk           (clk),
        .reset         (reset),
        .cmd           (n_cmd),
        .currents      (currents),
        .threshold     (threshold),
        .refrac_reload (refrac_reload),
        .fire_clear    (fire_clear),
        .spikes        (spikes),
        .refractory    (refractory)
    );

endmodule

// File: rtl/neuron_fire_unit.sv
`timescale 1ns/1ps
`include "nvu_cfg.svh"

module neuron_fire_unit
    import nvu_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  neuron_cmd_t  cmd,
    input  current_vec_t currents,
    input  cell_t        threshold,
    input  refrac_t      refrac_reload,
    output spike_vec_t   fire_clear,
    output spike_vec_t   spikes,
    output logic         refractory
);

    refrac_t    refrac_cnt;
    spike_vec_t above;        // Current strictly greater than threshold
    logic       fire_window;  // UPDATE while the counter is idle

    always_comb begin
        for (int i = 0; i < `NVU_NEURONS; i++) begin
            above[i] = currents[i*`NVU_CELL_W +: `NVU_CELL_W] > threshold;
        end
    end

    assign fire_window = (cmd.op == UPDATE) && (refrac_cnt == '0);
    assign fire_clear  = fire_window ? above : '0;  // Also clears currents in the accumulator
    assign refractory  = |refrac_cnt;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            spikes     <= '0;
            refrac_cnt <= '0;
        end else if (cmd.op == UPDATE) begin
            spikes <= fire_clear;                    // All zeros while refractory
            if (refrac_cnt != '0) begin
                refrac_cnt <= refrac_cnt - 1'b1;
            end else if (|fire_clear) begin
                refrac_cnt <= refrac_reload;         // Zero reload keeps it idle
            end
        end
    end

endmodule

// File: rtl/neuron_param_regs.sv
`timescale 1ns/1ps
`include "nvu_cfg.svh"

module neuron_param_regs
    import nvu_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  neuron_cmd_t cmd,
    input  data_bus_t   data,
    output cell_t       threshold,
    output refrac_t     refrac_reload
);

    // Both values are shared by all neurons

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            threshold     <= '0;
            refrac_reload <= '0;
        end else begin
            case (cmd.op)
                SET_THRESH: begin
                    threshold <= data[`NVU_CELL_W-1:0];        // Low nibble of the bus
                end
                SET_REFRAC: begin
                    refrac_reload <= data[`NVU_REFRAC_W-1:0];  // Low byte of the bus
                end
                default: begin
                end
            endcase
        end
    end

endmodule

// File: rtl/nvu_cfg.svh
`ifndef NVU_CFG_SVH
`define NVU_CFG_SVH

// Bank geometry
`define NVU_WORD_W     32
`define NVU_BANK_WORDS 16

// Neuron array geometry
`define NVU_NEURONS    128
`define NVU_CELL_W     4

// Refractory counter and reload width
`define NVU_REFRAC_W   8

`endif

// File: rtl/nvu_pkg.sv
`include "nvu_cfg.svh"

package nvu_pkg;

    typedef logic [`NVU_WORD_W-1:0] word_t;                      // One bank word
    typedef logic [$clog2(`NVU_BANK_WORDS)-1:0] bank_idx_t;      // Wraps modulo bank size
    typedef logic [`NVU_WORD_W*`NVU_BANK_WORDS-1:0] data_bus_t;  // Shared load bus
    typedef logic [`NVU_WORD_W*`NVU_BANK_WORDS-1:0] bank_vec_t;  // Word 0 lowest

    typedef logic [`NVU_CELL_W-1:0] cell_t;                      // Weight, current or threshold
    typedef logic [`NVU_NEURONS*`NVU_CELL_W-1:0] current_vec_t;  // Neuron 0 lowest
    typedef logic [`NVU_NEURONS-1:0] spike_vec_t;                // One bit per neuron
    typedef logic [`NVU_REFRAC_W-1:0] refrac_t;

    // Bank load modes
    typedef enum logic [1:0] {
        LOAD_NONE,
        LOAD_ONE,                                                // Data word 0 into word idx
        LOAD_FOUR,                                               // Data words 0..3 from idx
        LOAD_ALL                                                 // Whole bus into the bank
    } load_op_t;

    typedef struct packed {
        load_op_t  op;
        bank_idx_t idx;
    } reg_cmd_t;

    // Neuron side operations
    typedef enum logic [2:0] {
        N_NOP,
        SET_THRESH,
        SET_REFRAC,
        LOAD_CURRENT,
        ACCUMULATE,                                              // idx selects the spike window
        UPDATE
    } neuron_op_t;

    typedef struct packed {
        neuron_op_t op;
        bank_idx_t  idx;
    } neuron_cmd_t;

endpackage

// File: rtl/vector_reg_bank.sv
`timescale 1ns/1ps
`include "nvu_cfg.svh"

module vector_reg_bank
    import nvu_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  reg_cmd_t  cmd,
    input  data_bus_t data,
    output bank_vec_t words
);

    word_t mem [`NVU_BANK_WORDS];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int k = 0; k < `NVU_BANK_WORDS; k++) begin
                mem[k] <= '0;
            end
        end else begin
            case (cmd.op)
                LOAD_ONE: begin
                    mem[cmd.idx] <= data[`NVU_WORD_W-1:0];
                end
                LOAD_FOUR: begin
                    for (int k = 0; k < 4; k++) begin
                        // Index sum wraps at the bank size
                        mem[cmd.idx + bank_idx_t'(k)] <= data[k*`NVU_WORD_W +: `NVU_WORD_W];
                    end
                end
                LOAD_ALL: begin
                    for (int k = 0; k < `NVU_BANK_WORDS; k++) begin
                        mem[k] <= data[k*`NVU_WORD_W +: `NVU_WORD_W];
                    end
                end
                default: begin
                end
            endcase
        end
    end

    always_comb begin
        for (int k = 0; k < `NVU_BANK_WORDS; k++) begin
            words[k*`NVU_WORD_W +: `NVU_WORD_W] = mem[k];  // Word 0 in the low bits
        end
    end

endmodule

// File: tests/tb_neuro_vector_unit.sv
`timescale 1ns/1ps
`include "nvu_cfg.svh"

module tb_neuro_vector_unit
    import nvu_pkg::*;
;

    localparam int RESET_CYC    = 5;
    localparam int DIRECTED_CYC = 60;    // Budget for the directed phases
    localparam int RANDOM_CYC   = 1500;
    localparam int CYCLE_LIMIT  = 2 * (RESET_CYC + DIRECTED_CYC + RANDOM_CYC);
    localparam int WW = `NVU_WORD_W;
    localparam int CW = `NVU_CELL_W;

    localparam reg_cmd_t    NO_LOAD = '{op: LOAD_NONE, idx: '0};
    localparam neuron_cmd_t NO_OP   = '{op: N_NOP, idx: '0};

    logic         clk;
    logic         reset;
    reg_cmd_t     w_cmd;
    reg_cmd_t     s_cmd;
    neuron_cmd_t  n_cmd;
    data_bus_t    data;
    current_vec_t currents;
    spike_vec_t   spikes;
    logic         refractory;

    logic [31:0]  rng_state = 32'h2442;
    int           cycle_cnt = 0;
    int           err_cur = 0;
    int           err_spk = 0;
    int           err_ref = 0;

    // Reference model state
    bank_vec_t    m_wbank = '0;
    bank_vec_t    m_sbank = '0;
    current_vec_t m_cur = '0;
    cell_t        m_thr = '0;
    refrac_t      m_reload = '0;
    refrac_t      m_cnt = '0;
    spike_vec_t   m_spk = '0;

    neuro_vector_unit dut0 (
        .clk        (clk),
        .reset      (reset),
        .w_cmd      (w_cmd),
        .s_cmd      (s_cmd),
        .n_cmd      (n_cmd),
        .data       (data),
        .currents   (currents),
        .spikes     (spikes),
        .refractory (refractory)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test FAILED");
            $finish;
        end
    end

    // Two LCG steps keep the upper halves
    function automatic logic [31:0] next_rand();
        logic [15:0] hi;
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        hi = rng_state[31:16];
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return {hi, rng_state[31:16]};
    endfunction

    function automatic data_bus_t rand_bus();
        data_bus_t d;
        for (int k = 0; k < `NVU_BANK_WORDS; k++) begin
            d[k*WW +: WW] = next_rand();
        end
        return d;
    endfunction

    function automatic bank_vec_t bank_after(input bank_vec_t b, input reg_cmd_t c,
                                             input data_bus_t d);
        bank_vec_t r;
        int        j;
        r = b;
        case (c.op)
            LOAD_ONE: r[int'(c.idx)*WW +: WW] = d[WW-1:0];
            LOAD_FOUR: begin
                for (int k = 0; k < 4; k++) begin
                    j = (int'(c.idx) + k) % `NVU_BANK_WORDS;  // Wrapping word index
                    r[j*WW +: WW] = d[k*WW +: WW];
                end
            end
            LOAD_ALL: r = d;
            default: begin
            end
        endcase
        return r;
    endfunction

    // Next model state from the values before the edge
    task automatic model_step(input reg_cmd_t w, input reg_cmd_t s, input neuron_cmd_t n,
                              input data_bus_t d);
        current_vec_t nxt;
        int           wi;
        int           sum;
        logic         fired_any;
        nxt = m_cur;
        fired_any = 1'b0;
        case (n.op)
            SET_THRESH:   m_thr = d[3:0];
            SET_REFRAC:   m_reload = d[7:0];
            LOAD_CURRENT: nxt = d;
            ACCUMULATE: begin
                for (int i = 0; i < `NVU_NEURONS; i++) begin
                    wi = (int'(n.idx) + i / WW) % `NVU_BANK_WORDS;
                    if (m_sbank[wi*WW + i % WW]) begin
                        sum = (int'(m_cur[i*CW +: CW]) + int'(m_wbank[i*CW +: CW])) % 16;
                        nxt[i*CW +: CW] = cell_t'(sum);
                    end
                end
            end
            UPDATE: begin
                if (m_cnt == 0) begin
                    for (int i = 0; i < `NVU_NEURONS; i++) begin
                        m_spk[i] = m_cur[i*CW +: CW] > m_thr;
                        if (m_spk[i]) begin
                            nxt[i*CW +: CW] = '0;
                            fired_any = 1'b1;
                        end
                    end
                    if (fired_any) m_cnt = m_reload;
                end else begin
                    m_cnt = m_cnt - 1;
                    m_spk = '0;
                end
            end
            default: begin
            end
        endcase
        m_cur = nxt;
        m_wbank = bank_after(m_wbank, w, d);
        m_sbank = bank_after(m_sbank, s, d);
    endtask

    task automatic compare_currents(input string name, input current_vec_t got,
                                    input current_vec_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            err_cur++;
        end
    endtask

    task automatic compare_spikes(input string name, input spike_vec_t got,
                                  input spike_vec_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            err_spk++;
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
            err_ref++;
        end
    endtask

    // Check the previous command's effect, then drive the next one
    task automatic apply(input reg_cmd_t w, input reg_cmd_t s, input neuron_cmd_t n,
                         input data_bus_t d);
        @(negedge clk);
        compare_currents("currents", currents, m_cur);
        compare_spikes("spikes", spikes, m_spk);
        compare_flag("refractory", refractory, m_cnt != 0);
        w_cmd = w;
        s_cmd = s;
        n_cmd = n;
        data  = d;
        model_step(w, s, n, d);
    endtask

    function automatic reg_cmd_t bank_cmd(input load_op_t op, input int idx);
        return '{op: op, idx: bank_idx_t'(idx)};
    endfunction

    function automatic neuron_cmd_t ncmd(input neuron_op_t op, input int idx);
        return '{op: op, idx: bank_idx_t'(idx)};
    endfunction

    task automatic set_params(input int thr, input int reload);
        data_bus_t d;
        d = rand_bus();
        d[3:0] = thr[3:0];
        apply(NO_LOAD, NO_LOAD, ncmd(SET_THRESH, 0), d);
        d = rand_bus();
        d[7:0] = reload[7:0];
        apply(NO_LOAD, NO_LOAD, ncmd(SET_REFRAC, 0), d);
    endtask

    task automatic run_random();
        logic [31:0] r;
        neuron_cmd_t nc;
        data_bus_t   d;
        for (int c = 0; c < RANDOM_CYC; c++) begin
            r = next_rand();
            nc = '{op: neuron_op_t'(r[23:16] % 6), idx: bank_idx_t'(r[27:24])};
            d = rand_bus();
            if (nc.op == SET_REFRAC) d[7:0] = {5'd0, r[30:28]};  // Short refractory spans
            apply(bank_cmd(load_op_t'(r[1:0]), r[7:4]), bank_cmd(load_op_t'(r[9:8]), r[15:12]),
                  nc, d);
        end
    endtask

    initial begin
        reset = 1'b1;
        w_cmd = NO_LOAD;
        s_cmd = NO_LOAD;
        n_cmd = NO_OP;
        data  = '0;
        repeat (RESET_CYC) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        apply(NO_LOAD, NO_LOAD, NO_OP, '0);                   // Reset values
        apply(bank_cmd(LOAD_ALL, 0), NO_LOAD, NO_OP, rand_bus());
        apply(NO_LOAD, bank_cmd(LOAD_ALL, 0), NO_OP, rand_bus());
        apply(NO_LOAD, NO_LOAD, ncmd(LOAD_CURRENT, 0), rand_bus());
        apply(NO_LOAD, NO_LOAD, ncmd(ACCUMULATE, 0), rand_bus());
        apply(NO_LOAD, NO_LOAD, ncmd(ACCUMULATE, 0), rand_bus());

        // Loads near the top of the bank
        apply(bank_cmd(LOAD_ONE, 13), bank_cmd(LOAD_FOUR, 15), NO_OP, rand_bus());
        apply(bank_cmd(LOAD_FOUR, 14), bank_cmd(LOAD_ONE, 14), NO_OP, rand_bus());
        apply(bank_cmd(LOAD_ONE, 15), bank_cmd(LOAD_FOUR, 13), NO_OP, rand_bus());
        apply(NO_LOAD, NO_LOAD, ncmd(ACCUMULATE, 13), rand_bus());
        apply(NO_LOAD, NO_LOAD, ncmd(ACCUMULATE, 15), rand_bus());
        apply(NO_LOAD, NO_LOAD, ncmd(ACCUMULATE, 2), rand_bus());
        apply(bank_cmd(LOAD_FOUR, 15), bank_cmd(LOAD_ONE, 0), ncmd(ACCUMULATE, 14), rand_bus());

        // Exact current load, then bank loads beside an accumulate
        apply(NO_LOAD, NO_LOAD, ncmd(LOAD_CURRENT, 0), rand_bus());
        apply(bank_cmd(LOAD_ALL, 0), bank_cmd(LOAD_ALL, 0), ncmd(ACCUMULATE, 5), rand_bus());
        apply(NO_LOAD, NO_LOAD, ncmd(ACCUMULATE, 5), rand_bus());

        // Firing and refractory countdown
        set_params(7, 3);
        apply(NO_LOAD, NO_LOAD, ncmd(LOAD_CURRENT, 0), rand_bus());
        apply(NO_LOAD, NO_LOAD, ncmd(UPDATE, 0), rand_bus());
        apply(NO_LOAD, NO_LOAD, NO_OP, rand_bus());           // Spikes hold
        repeat (3) apply(NO_LOAD, NO_LOAD, ncmd(UPDATE, 0), rand_bus());
        apply(NO_LOAD, NO_LOAD, ncmd(LOAD_CURRENT, 0), rand_bus());
        apply(NO_LOAD, NO_LOAD, ncmd(UPDATE, 0), rand_bus());
        set_params(4, 0);
        repeat (3) apply(NO_LOAD, NO_LOAD, ncmd(UPDATE, 0), rand_bus());
        apply(NO_LOAD, NO_LOAD, ncmd(LOAD_CURRENT, 0), rand_bus());
        repeat (2) apply(NO_LOAD, NO_LOAD, ncmd(UPDATE, 0), rand_bus());

        run_random();
        apply(NO_LOAD, NO_LOAD, NO_OP, '0);                   // Last check

        $display("Errors: currents %0d, spikes %0d, refractory %0d", err_cur, err_spk, err_ref);
        if (err_cur + err_spk + err_ref == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
